//--- compile.f
+incdir+common
common/vread_pkg.sv
common/addr_gen_cfg_if.sv
vread/address_gen.sv
vread/memory_writer.sv
vread/vread.sv
hw/dp_ram.sv
hw/vread_top.sv
tb/tb_vread.sv

//--- Bender.yml
package:
  name: vread

export_include_dirs:
  - common

sources:
  - common/vread_pkg.sv
  - common/addr_gen_cfg_if.sv
  - vread/address_gen.sv
  - vread/memory_writer.sv
  - vread/vread.sv
  - hw/dp_ram.sv
  - hw/vread_top.sv

  - target: test
    files:
      - tb/tb_vread.sv

//--- tb/tb_vread.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defines.svh"

module tb_vread import vread_pkg::*; ();

   localparam int N_RAND       = 3;
   localparam int BURST_WORDS  = 255 + 2 * 32;
   localparam int OUT_STEPS    = 255 + N_RAND * (4 * 8 + 63) + 2 * (64 + 63);
   localparam int WATCH_CYCLES = 8 * (BURST_WORDS + OUT_STEPS) + 200;
   localparam int MSB          = `VREAD_ADDR_W - 1;

   logic      clk;
   logic      rst;
   logic      run_i;
   logic      done_o;
   logic      bus_valid_o;
   logic      bus_ready_i;
   bus_addr_t bus_addr_o;
   len_t      bus_len_o;
   bus_data_t bus_rdata_i;
   logic      bus_last_i;
   bus_addr_t ext_addr_i;
   len_t      read_len_i;
   logic      read_enable_i;
   logic      pingpong_i;
   period_t   read_per_i;
   period_t   read_duty_i;
   mem_addr_t read_incr_i;
   mem_addr_t read_shift_i;
   mem_addr_t read_iter_i;
   mem_addr_t out_start_i;
   mem_addr_t out_incr_i;
   mem_addr_t out_shift_i;
   mem_addr_t out_iter_i;
   period_t   out_per_i;
   period_t   out_duty_i;
   delay_t    out_delay_i;
   out_data_t out_o;
   logic      out_valid_o;

   // reference model state
   bus_data_t model_ram [2 ** `VREAD_ADDR_W];
   logic      model_pp;
   mem_addr_t seq_q [$];
   mem_addr_t wr_q [$];
   mem_addr_t written_q [$];
   out_data_t sym_q [$];

   int    seed;
   int    bus_seed;
   int    beats_left;
   int    beat_cnt;
   int    err_word;
   int    err_sym;
   int    err_addr;
   int    err_ctrl;
   int    tries;
   logic  ok;
   string test_name;

   vread_top u_dut (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .done_o        (done_o),
      .bus_valid_o   (bus_valid_o),
      .bus_ready_i   (bus_ready_i),
      .bus_addr_o    (bus_addr_o),
      .bus_len_o     (bus_len_o),
      .bus_rdata_i   (bus_rdata_i),
      .bus_last_i    (bus_last_i),
      .ext_addr_i    (ext_addr_i),
      .read_len_i    (read_len_i),
      .read_enable_i (read_enable_i),
      .pingpong_i    (pingpong_i),
      .read_per_i    (read_per_i),
      .read_duty_i   (read_duty_i),
      .read_incr_i   (read_incr_i),
      .read_shift_i  (read_shift_i),
      .read_iter_i   (read_iter_i),
      .out_start_i   (out_start_i),
      .out_incr_i    (out_incr_i),
      .out_shift_i   (out_shift_i),
      .out_iter_i    (out_iter_i),
      .out_per_i     (out_per_i),
      .out_duty_i    (out_duty_i),
      .out_delay_i   (out_delay_i),
      .out_o         (out_o),
      .out_valid_o   (out_valid_o)
   );

   always #10 clk = ~clk;

   task automatic check_word(input string name, input bus_data_t exp, input bus_data_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         err_word++;
      end
   endtask

   task automatic check_sym(input string name, input out_data_t exp, input out_data_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         err_sym++;
      end
   endtask

   task automatic check_addr(input string name, input bus_addr_t exp, input bus_addr_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         err_addr++;
      end
   endtask

   task automatic check_len(input string name, input len_t exp, input len_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
         err_ctrl++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
         err_ctrl++;
      end
   endtask

   // one loop level of start + i*shift + p*incr while p < duty
   task automatic gen_seq(input mem_addr_t start, input mem_addr_t incr, input mem_addr_t shift,
                          input mem_addr_t iter, input period_t per, input period_t duty);
      mem_addr_t base;
      mem_addr_t a;
      seq_q.delete();
      base = start;
      for (int i = 0; i < iter; i++) begin
         for (int p = 0; p < per; p++) begin
            a = base + mem_addr_t'(p) * incr;
            if (p < duty) begin
               seq_q.push_back(a);
            end
         end
         base = base + shift;
      end
   endtask

   function automatic out_data_t predict_sym(input mem_addr_t s, input logic pp);
      mem_addr_t w;
      w = s;
      w[MSB] = 1'b0;
      w = w >> 1;
      w[MSB] = pp;
      return s[0] ? model_ram[w][31:16] : model_ram[w][15:0];
   endfunction

   // burst of duty*iter words laid out back to back from word 0
   task automatic config_read(input period_t duty, input mem_addr_t iter);
      read_enable_i = 1'b1;
      read_duty_i   = duty;
      read_per_i    = duty + period_t'($random(seed) & 3);
      read_incr_i   = 1;
      read_shift_i  = mem_addr_t'(duty);
      read_iter_i   = iter;
      read_len_i    = len_t'(duty * iter);
      ext_addr_i    = $random(seed);
   endtask

   task automatic config_out(input mem_addr_t start, input mem_addr_t incr, input mem_addr_t shift,
                             input mem_addr_t iter, input period_t per, input period_t duty);
      out_start_i = start;
      out_incr_i  = incr;
      out_shift_i = shift;
      out_iter_i  = iter;
      out_per_i   = per;
      out_duty_i  = duty;
   endtask

   task automatic run_and_wait();
      int        exp_beats;
      bus_addr_t exp_addr;
      exp_beats = 0;
      exp_addr  = ext_addr_i;
      model_pp  = pingpong_i ? !model_pp : 1'b0;
      beat_cnt  = 0;
      written_q.delete();
      wr_q.delete();
      if (read_enable_i) begin
         gen_seq('0, read_incr_i, read_shift_i, read_iter_i, read_per_i, read_duty_i);
         foreach (seq_q[k]) begin
            wr_q.push_back(pingpong_i ? {!model_pp, seq_q[k][MSB-1:0]} : seq_q[k]);
         end
         exp_beats = read_len_i;
      end
      beats_left = exp_beats;
      gen_seq(out_start_i, out_incr_i, out_shift_i, out_iter_i, out_per_i, out_duty_i);
      foreach (seq_q[k]) begin
         sym_q.push_back(predict_sym(seq_q[k], pingpong_i && model_pp));
      end
      run_i = 1'b1;
      @(posedge clk);
      #2;
      run_i = 1'b0;
      // the bus address must stay latched once the input moves on
      ext_addr_i = $random(seed);
      check_flag({test_name, " done low"}, 1'b0, done_o);
      while (done_o !== 1'b1) begin
         @(posedge clk);
         #2;
      end
      if (beat_cnt != exp_beats) begin
         $display("%s: %0d bus beats seen, %0d expected", test_name, beat_cnt, exp_beats);
         err_ctrl++;
      end
      if (sym_q.size() != 0) begin
         $display("%s: %0d predicted symbols never came out", test_name, sym_q.size());
         err_sym++;
         sym_q.delete();
      end
      // every beat must have landed at its model address
      foreach (written_q[k]) begin
         check_word(test_name, model_ram[written_q[k]], u_dut.u_ram.mem[written_q[k]]);
      end
      if (read_enable_i) begin
         check_addr(test_name, exp_addr, bus_addr_o);
         check_len(test_name, read_len_i, bus_len_o);
      end
   endtask

   // bus slave with random ready gaps
   always @(posedge clk) begin
      logic gap;
      #2;
      gap         = ($random(bus_seed) & 3) == 0;
      bus_rdata_i = $random(bus_seed);
      bus_ready_i = !rst && bus_valid_o && (beats_left > 0) && !gap;
      bus_last_i  = bus_ready_i && (beats_left == 1);
   end

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      mem_addr_t a;
      if (!rst) begin
         if (bus_valid_o && bus_ready_i) begin
            if (wr_q.size() == 0) begin
               $display("%s: bus beat with no write address expected", test_name);
               err_ctrl++;
            end else begin
               a = wr_q.pop_front();
               model_ram[a] = bus_rdata_i;
               written_q.push_back(a);
            end
            beat_cnt++;
            beats_left--;
         end
         if (out_valid_o) begin
            if (sym_q.size() == 0) begin
               $display("%s: output symbol %h with no prediction", test_name, out_o);
               err_sym++;
            end else begin
               check_sym(test_name, sym_q.pop_front(), out_o);
            end
         end
      end
   end

   initial begin
      repeat (WATCH_CYCLES) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial begin
      seed          = 32'h5e6e_838f;
      bus_seed      = seed ^ 32'h0000_ffff;
      clk           = 1'b0;
      rst           = 1'b1;
      run_i         = 1'b0;
      bus_ready_i   = 1'b0;
      bus_rdata_i   = '0;
      bus_last_i    = 1'b0;
      ext_addr_i    = '0;
      read_len_i    = '0;
      read_enable_i = 1'b0;
      pingpong_i    = 1'b0;
      read_per_i    = '0;
      read_duty_i   = '0;
      read_incr_i   = '0;
      read_shift_i  = '0;
      read_iter_i   = '0;
      config_out('0, '0, '0, '0, '0, '0);
      out_delay_i   = '0;
      model_pp      = 1'b0;
      beats_left    = 0;
      err_word      = 0;
      err_sym       = 0;
      err_addr      = 0;
      err_ctrl      = 0;
      test_name     = "reset";
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      check_flag("reset done", 1'b1, done_o);
      check_flag("reset bus valid", 1'b0, bus_valid_o);
      check_flag("reset out valid", 1'b0, out_valid_o);

      // words 0..254 of the lower half
      test_name = "burst";
      config_read(15, 17);
      run_and_wait();

      test_name = "linear";
      read_enable_i = 1'b0;
      config_out('0, 1, '0, 1, 255, 255);
      run_and_wait();

      for (int r = 0; r < N_RAND; r++) begin
         test_name = $sformatf("strided %0d", r);
         ok    = 1'b0;
         tries = 0;
         // redraw until every symbol hits a written word
         while (!ok && tries < 100) begin
            out_start_i = $random(seed);
            out_incr_i  = mem_addr_t'($random(seed) & 7);
            out_shift_i = mem_addr_t'($random(seed) & 63);
            out_iter_i  = mem_addr_t'(1 + ($random(seed) & 3));
            out_per_i   = period_t'(1 + ($random(seed) & 7));
            out_duty_i  = period_t'($unsigned($random(seed)) % (out_per_i + 1));
            out_delay_i = delay_t'($random(seed));
            gen_seq(out_start_i, out_incr_i, out_shift_i, out_iter_i, out_per_i, out_duty_i);
            ok = 1'b1;
            foreach (seq_q[k]) begin
               if (^predict_sym(seq_q[k], 1'b0) === 1'bx) begin
                  ok = 1'b0;
               end
            end
            tries++;
         end
         if (!ok) begin
            $display("%s: no strided pattern within written words found", test_name);
            err_ctrl++;
         end else begin
            run_and_wait();
         end
      end

      // fill one half, then swap and drain
      pingpong_i  = 1'b1;
      out_delay_i = '0;
      test_name   = "pingpong fill";
      config_read(8, 4);
      config_out('0, '0, '0, '0, '0, '0);
      run_and_wait();

      test_name = "pingpong swap";
      config_read(8, 4);
      config_out('0, 1, '0, 1, 64, 64);
      out_delay_i = delay_t'($random(seed));
      run_and_wait();

      test_name = "pingpong drain";
      read_enable_i = 1'b0;
      run_and_wait();

      $display("errors: word %0d, symbol %0d, address %0d, control %0d",
               err_word, err_sym, err_addr, err_ctrl);
      if (err_word + err_sym + err_addr + err_ctrl == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/vread_top.sv
`timescale 1ns/1ps
`default_nettype none

module vread_top import vread_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      run_i,
   output logic      done_o,

   output logic      bus_valid_o,
   input  logic      bus_ready_i,
   output bus_addr_t bus_addr_o,
   output len_t      bus_len_o,
   input  bus_data_t bus_rdata_i,
   input  logic      bus_last_i,

   input  bus_addr_t ext_addr_i,
   input  len_t      read_len_i,
   input  logic      read_enable_i,
   input  logic      pingpong_i,

   input  period_t   read_per_i,
   input  period_t   read_duty_i,
   input  mem_addr_t read_incr_i,
   input  mem_addr_t read_shift_i,
   input  mem_addr_t read_iter_i,

   input  mem_addr_t out_start_i,
   input  mem_addr_t out_incr_i,
   input  mem_addr_t out_shift_i,
   input  mem_addr_t out_iter_i,
   input  period_t   out_per_i,
   input  period_t   out_duty_i,
   input  delay_t    out_delay_i,

   output out_data_t out_o,
   output logic      out_valid_o
);

   logic      wr_en;
   mem_addr_t wr_addr;
   bus_data_t wr_data;
   logic      rd_en;
   mem_addr_t rd_addr;
   bus_data_t rd_data;

   vread u_core (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .done_o        (done_o),
      .bus_valid_o   (bus_valid_o),
      .bus_ready_i   (bus_ready_i),
      .bus_addr_o    (bus_addr_o),
      .bus_len_o     (bus_len_o),
      .bus_rdata_i   (bus_rdata_i),
      .bus_last_i    (bus_last_i),
      .ext_addr_i    (ext_addr_i),
      .read_len_i    (read_len_i),
      .read_enable_i (read_enable_i),
      .pingpong_i    (pingpong_i),
      .read_per_i    (read_per_i),
      .read_duty_i   (read_duty_i),
      .read_incr_i   (read_incr_i),
      .read_shift_i  (read_shift_i),
      .read_iter_i   (read_iter_i),
      .out_start_i   (out_start_i),
      .out_incr_i    (out_incr_i),
      .out_shift_i   (out_shift_i),
      .out_iter_i    (out_iter_i),
      .out_per_i     (out_per_i),
      .out_duty_i    (out_duty_i),
      .out_delay_i   (out_delay_i),
      .wr_en_o       (wr_en),
      .wr_addr_o     (wr_addr),
      .wr_data_o     (wr_data),
      .rd_en_o       (rd_en),
      .rd_addr_o     (rd_addr),
      .rd_data_i     (rd_data),
      .out_o         (out_o),
      .out_valid_o   (out_valid_o)
   );

   dp_ram u_ram (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

endmodule

`default_nettype wire

//--- hw/dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defines.svh"

module dp_ram import vread_pkg::*; (
   input  logic      clk,

   input  logic      wr_en_i,
   input  mem_addr_t wr_addr_i,
   input  bus_data_t wr_data_i,

   input  logic      rd_en_i,
   input  mem_addr_t rd_addr_i,
   output bus_data_t rd_data_o
);

   localparam int DEPTH = 2 ** `VREAD_ADDR_W;

   bus_data_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read with one cycle latency
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

//--- vread/vread.sv
`timescale 1ns/1ps
`default_nettype none

`include "vread_defines.svh"

module vread import vread_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      run_i,
   output logic      done_o,

   output logic      bus_valid_o,
   input  logic      bus_ready_i,
   output bus_addr_t bus_addr_o,
   output len_t      bus_len_o,
   input  bus_data_t bus_rdata_i,
   input  logic      bus_last_i,

   input  bus_addr_t ext_addr_i,
   input  len_t      read_len_i,
   input  logic      read_enable_i,
   input  logic      pingpong_i,

   input  period_t   read_per_i,
   input  period_t   read_duty_i,
   input  mem_addr_t read_incr_i,
   input  mem_addr_t read_shift_i,
   input  mem_addr_t read_iter_i,

   input  mem_addr_t out_start_i,
   input  mem_addr_t out_incr_i,
   input  mem_addr_t out_shift_i,
   input  mem_addr_t out_iter_i,
   input  period_t   out_per_i,
   input  period_t   out_duty_i,
   input  delay_t    out_delay_i,

   output logic      wr_en_o,
   output mem_addr_t wr_addr_o,
   output bus_data_t wr_data_o,

   output logic      rd_en_o,
   output mem_addr_t rd_addr_o,
   input  bus_data_t rd_data_i,

   output out_data_t out_o,
   output logic      out_valid_o
);

   localparam int MSB = `VREAD_ADDR_W - 1;

   logic      done_read_q;
   logic      done_out_q;
   logic      pp_state_q;
   logic      beat;
   logic      data_ready;

   logic      rgen_valid;
   logic      rgen_ready;
   mem_addr_t rgen_addr;
   mem_addr_t wgen_addr;

   logic      ogen_valid;
   logic      ogen_done;
   mem_addr_t sym_addr;
   logic      sel_q;
   logic      out_valid_q;

   addr_gen_cfg_if u_read_cfg ();
   addr_gen_cfg_if u_out_cfg ();

   assign beat   = bus_valid_o && bus_ready_i;
   assign done_o = done_read_q && done_out_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_read_q <= 1'b1;
         done_out_q  <= 1'b1;
         pp_state_q  <= 1'b0;
         bus_addr_o  <= '0;
      end else if (run_i) begin
         done_read_q <= !read_enable_i;
         done_out_q  <= 1'b0;
         pp_state_q  <= pingpong_i ? !pp_state_q : 1'b0;
         if (read_enable_i) begin
            bus_addr_o <= ext_addr_i;
         end
      end else begin
         if (beat && bus_last_i) begin
            done_read_q <= 1'b1;
         end
         if (ogen_done) begin
            done_out_q <= 1'b1;
         end
      end
   end

   // read side walks from 0 with no delay
   assign u_read_cfg.start      = '0;
   assign u_read_cfg.incr       = read_incr_i;
   assign u_read_cfg.shift      = read_shift_i;
   assign u_read_cfg.iterations = read_iter_i;
   assign u_read_cfg.period     = read_per_i;
   assign u_read_cfg.duty       = read_duty_i;
   assign u_read_cfg.delay      = '0;

   address_gen u_read_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i && read_enable_i),
      .cfg     (u_read_cfg.sink),
      .valid_o (rgen_valid),
      .ready_i (rgen_ready),
      .addr_o  (rgen_addr),
      .done_o  ()
   );

   // writes land in the half not being output
   assign wgen_addr = {pingpong_i ? !pp_state_q : rgen_addr[MSB], rgen_addr[MSB-1:0]};

   memory_writer u_writer (
      .clk          (clk),
      .rst          (rst),
      .gen_valid_i  (rgen_valid),
      .gen_ready_o  (rgen_ready),
      .gen_addr_i   (wgen_addr),
      .data_valid_i (beat),
      .data_ready_o (data_ready),
      .data_i       (bus_rdata_i),
      .wr_en_o      (wr_en_o),
      .wr_addr_o    (wr_addr_o),
      .wr_data_o    (wr_data_o)
   );

   assign bus_valid_o = data_ready && !done_read_q;
   assign bus_len_o   = read_len_i;

   assign u_out_cfg.start      = out_start_i;
   assign u_out_cfg.incr       = out_incr_i;
   assign u_out_cfg.shift      = out_shift_i;
   assign u_out_cfg.iterations = out_iter_i;
   assign u_out_cfg.period     = out_per_i;
   assign u_out_cfg.duty       = out_duty_i;
   assign u_out_cfg.delay      = out_delay_i;

   address_gen u_out_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg     (u_out_cfg.sink),
      .valid_o (ogen_valid),
      .ready_i (1'b1),
      .addr_o  (sym_addr),
      .done_o  (ogen_done)
   );

   // two symbols per RAM word
   assign rd_en_o   = ogen_valid;
   assign rd_addr_o = {pingpong_i && pp_state_q, 1'b0, sym_addr[MSB-1:1]};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= ogen_valid;
      end
   end

   // lines up with the RAM read latency
   always_ff @(posedge clk) begin
      sel_q <= sym_addr[0];
   end

   assign out_o = sel_q ? rd_data_i[2*`VREAD_OUT_W-1:`VREAD_OUT_W]
                        : rd_data_i[`VREAD_OUT_W-1:0];
   assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- vread/memory_writer.sv
`timescale 1ns/1ps
`default_nettype none

module memory_writer import vread_pkg::*; (
   input  logic      clk,
   input  logic      rst,

   input  logic      gen_valid_i,
   output logic      gen_ready_o,
   input  mem_addr_t gen_addr_i,

   input  logic      data_valid_i,
   output logic      data_ready_o,
   input  bus_data_t data_i,

   output logic      wr_en_o,
   output mem_addr_t wr_addr_o,
   output bus_data_t wr_data_o
);

   logic      full_q;
   mem_addr_t addr_q;
   logic      write;

   // a beat only counts while an address is held
   assign data_ready_o = full_q;
   assign write        = data_valid_i && full_q;

   // slot frees on a write and may refill in the same cycle
   assign gen_ready_o = !full_q || write;

   assign wr_en_o   = write;
   assign wr_addr_o = addr_q;
   assign wr_data_o = data_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         full_q <= 1'b0;
      end else if (gen_ready_o) begin
         full_q <= gen_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (gen_ready_o && gen_valid_i) begin
         addr_q <= gen_addr_i;
      end
   end

endmodule

`default_nettype wire

//--- vread/address_gen.sv
`timescale 1ns/1ps
`default_nettype none

module address_gen import vread_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         run_i,
   addr_gen_cfg_if.sink cfg,
   output logic         valid_o,
   input  logic         ready_i,
   output mem_addr_t    addr_o,
   output logic         done_o
);

   ag_state_e state_q;

   // latched configuration
   mem_addr_t incr_q;
   mem_addr_t shift_q;
   mem_addr_t iter_q;
   period_t   period_q;
   period_t   duty_q;

   // walk state
   mem_addr_t iter_cnt;
   period_t   per_cnt;
   delay_t    delay_cnt;
   mem_addr_t addr_q;
   mem_addr_t base_q;

   logic empty;
   logic in_duty;
   logic advance;
   logic per_last;
   logic iter_last;

   assign empty     = (iter_q == '0);
   assign in_duty   = (per_cnt < duty_q);
   assign per_last  = (period_q == '0) || (per_cnt == period_q - period_t'(1));
   assign iter_last = (iter_cnt == iter_q - mem_addr_t'(1));

   // off-duty steps pass one per cycle, duty steps wait for ready
   assign valid_o = (state_q == AG_RUN) && !empty && in_duty;
   assign advance = (state_q == AG_RUN) && !empty && (!in_duty || ready_i);
   assign addr_o  = addr_q;

   // a run restarts the walk even during trailing off-duty steps
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= AG_IDLE;
         done_o  <= 1'b1;
      end else if (run_i) begin
         done_o  <= 1'b0;
         state_q <= (cfg.delay == '0) ? AG_RUN : AG_DELAY;
      end else begin
         case (state_q)
            AG_DELAY: begin
               if (delay_cnt == delay_t'(1)) begin
                  state_q <= AG_RUN;
               end
            end
            AG_RUN: begin
               if (empty || (advance && per_last && iter_last)) begin
                  state_q <= AG_IDLE;
                  done_o  <= 1'b1;
               end
            end
            default: state_q <= AG_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (run_i) begin
         incr_q    <= cfg.incr;
         shift_q   <= cfg.shift;
         iter_q    <= cfg.iterations;
         period_q  <= cfg.period;
         duty_q    <= cfg.duty;
         delay_cnt <= cfg.delay;
         addr_q    <= cfg.start;
         base_q    <= cfg.start;
         iter_cnt  <= '0;
         per_cnt   <= '0;
      end else if (state_q == AG_DELAY) begin
         delay_cnt <= delay_cnt - delay_t'(1);
      end else if (advance) begin
         if (per_last) begin
            // next iteration restarts from the shifted base
            per_cnt  <= '0;
            iter_cnt <= iter_cnt + mem_addr_t'(1);
            base_q   <= base_q + shift_q;
            addr_q   <= base_q + shift_q;
         end else begin
            per_cnt <= per_cnt + period_t'(1);
            addr_q  <= addr_q + incr_q;
         end
      end
   end

endmodule

`default_nettype wire

//--- common/addr_gen_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface addr_gen_cfg_if import vread_pkg::*; ();

   mem_addr_t start;
   mem_addr_t incr;
   mem_addr_t shift;
   mem_addr_t iterations;
   period_t   period;
   period_t   duty;
   delay_t    delay;

   modport src (
      output start, incr, shift, iterations, period, duty, delay
   );

   // generator side only reads
   modport sink (
      input start, incr, shift, iterations, period, duty, delay
   );

endinterface

`default_nettype wire

//--- common/vread_pkg.sv
`default_nettype none

`include "vread_defines.svh"

package vread_pkg;

   // bus side
   typedef logic [`VREAD_BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [`VREAD_BUS_DATA_W-1:0] bus_data_t;

   // output stream
   typedef logic [`VREAD_OUT_W-1:0] out_data_t;

   // local RAM and generator addresses
   typedef logic [`VREAD_ADDR_W-1:0] mem_addr_t;

   // generator counts
   typedef logic [`VREAD_PERIOD_W-1:0] period_t;
   typedef logic [`VREAD_DELAY_W-1:0] delay_t;

   typedef logic [`VREAD_LEN_W-1:0] len_t;

   // address generator FSM
   typedef enum logic [1:0] {
      AG_IDLE,
      AG_DELAY,
      AG_RUN
   } ag_state_e;

endpackage

`default_nettype wire

//--- common/vread_defines.svh
`ifndef VREAD_DEFINES_SVH
`define VREAD_DEFINES_SVH

// bus side
`define VREAD_BUS_ADDR_W 32
`define VREAD_BUS_DATA_W 32

// output symbol is half a bus word
`define VREAD_OUT_W 16

// RAM word address whose MSB picks the ping-pong half
`define VREAD_ADDR_W 10

// generator counters
`define VREAD_PERIOD_W 8
`define VREAD_DELAY_W 6

// burst length
`define VREAD_LEN_W 8

`endif
